/* Bender.yml */
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - mips_stage_reg.sv
  - mips_fetch.sv
  - mips_decode.sv
  - mips_execute.sv
  - mips_memory.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_checker.sv
      - tb_mips_core.sv

/* mips_core.f */
mips_pkg.sv
mips_stage_reg.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_core.sv
mips_core_checker.sv
tb_mips_core.sv

/* mips_core.sv */
//--------------------------------------------------------------------
// Five-stage MIPS integer core
// Fetch, decode, execute and memory with the four stage registers,
// writeback sits in decode
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_cache_stall_n,
    input  logic                      d_cache_stall_n,
    // Instruction side
    output logic                      ireq,
    output logic [mips_pkg::xlen-1:0] iaddr,
    input  logic [mips_pkg::xlen-1:0] idata,
    // Data side
    output logic                      dreq,
    output logic                      dwrite,
    output logic [mips_pkg::xlen-1:0] daddr,
    output logic [mips_pkg::xlen-1:0] dwdata,
    input  logic [mips_pkg::xlen-1:0] drdata
);

    // Stage payloads, d side and q side
    mips_pkg::if_id_t  if_id_d;
    mips_pkg::if_id_t  if_id_q;
    mips_pkg::id_ex_t  id_ex_d;
    mips_pkg::id_ex_t  id_ex_q;
    mips_pkg::ex_mem_t ex_mem_d;
    mips_pkg::ex_mem_t ex_mem_q;
    mips_pkg::mem_wb_t mem_wb_d;
    mips_pkg::mem_wb_t mem_wb_q;

    // Pipeline control
    logic                      freeze;
    logic                      id_hold;
    logic                      bubble;
    logic                      branch_taken;
    logic [mips_pkg::xlen-1:0] branch_target;

    //----------------------------------------------------------------
    // IF
    //----------------------------------------------------------------
    mips_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .freeze        (freeze),
        .id_hold       (id_hold),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .idata         (idata),
        .iaddr         (iaddr),
        .ireq          (ireq),
        .if_id         (if_id_d)
    );

    mips_stage_reg #(.payload_t(mips_pkg::if_id_t)) u_if_id (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .hold   (id_hold),
        .bubble (1'b0),
        .d      (if_id_d),
        .q      (if_id_q)
    );

    //----------------------------------------------------------------
    // ID and WB
    //----------------------------------------------------------------
    mips_decode u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_cache_stall_n (i_cache_stall_n),
        .d_cache_stall_n (d_cache_stall_n),
        .if_id           (if_id_q),
        .id_ex_q         (id_ex_q),
        .ex_mem_q        (ex_mem_q),
        .mem_wb_q        (mem_wb_q),
        .freeze          (freeze),
        .id_hold         (id_hold),
        .bubble          (bubble),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .id_ex           (id_ex_d)
    );

    // Hazard bubbles land here
    mips_stage_reg #(.payload_t(mips_pkg::id_ex_t)) u_id_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .hold   (1'b0),
        .bubble (bubble),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    //----------------------------------------------------------------
    // EX
    //----------------------------------------------------------------
    mips_execute u_execute (
        .id_ex_q  (id_ex_q),
        .ex_mem_q (ex_mem_q),
        .mem_wb_q (mem_wb_q),
        .ex_mem   (ex_mem_d)
    );

    mips_stage_reg #(.payload_t(mips_pkg::ex_mem_t)) u_ex_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    //----------------------------------------------------------------
    // MEM
    //----------------------------------------------------------------
    mips_memory u_memory (
        .ex_mem_q (ex_mem_q),
        .drdata   (drdata),
        .dreq     (dreq),
        .dwrite   (dwrite),
        .daddr    (daddr),
        .dwdata   (dwdata),
        .mem_wb   (mem_wb_d)
    );

    mips_stage_reg #(.payload_t(mips_pkg::mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

endmodule

`default_nettype wire

/* mips_core_checker.sv */
//--------------------------------------------------------------------
// Bus protocol checker for the MIPS core
// Bound to mips_core, watches the request strobes and the data stall
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_core_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        d_cache_stall_n,
    input logic        ireq,
    input logic [31:0] iaddr,
    input logic        dreq,
    input logic        dwrite,
    input logic [31:0] daddr,
    input logic [31:0] dwdata
);

    // Set once a reset edge has cleared the flops
    logic rst_seen;

    initial rst_seen = 1'b0;

    always @(posedge clk) begin
        if (!rst_n) begin
            rst_seen <= 1'b1;
        end
    end

    assert property (@(posedge clk) (rst_seen && !rst_n) |-> (!ireq && !dreq && !dwrite))
        else $error("request strobe high during reset");

    assert property (@(posedge clk) disable iff (!rst_n) dwrite |-> dreq)
        else $error("dwrite without dreq");

    assert property (@(posedge clk) disable iff (!rst_n) iaddr[1:0] == 2'b00)
        else $error("iaddr not word aligned");

    // A stalled data access holds every request field
    assert property (@(posedge clk) disable iff (!rst_n)
        !d_cache_stall_n |=> ($stable(dreq) && $stable(dwrite) &&
                              $stable(daddr) && $stable(dwdata)))
        else $error("data request changed during a data stall");

endmodule

bind mips_core mips_core_checker i_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .d_cache_stall_n (d_cache_stall_n),
    .ireq            (ireq),
    .iaddr           (iaddr),
    .dreq            (dreq),
    .dwrite          (dwrite),
    .daddr           (daddr),
    .dwdata          (dwdata)
);

`default_nettype wire

/* mips_decode.sv */
//--------------------------------------------------------------------
// Decode stage
// Instruction decode, register file with writeback, BEQ
// resolution, hazard detection and pipeline freeze
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_cache_stall_n,
    input  logic                      d_cache_stall_n,
    input  mips_pkg::if_id_t          if_id,
    input  mips_pkg::id_ex_t          id_ex_q,
    input  mips_pkg::ex_mem_t         ex_mem_q,
    input  mips_pkg::mem_wb_t         mem_wb_q,
    output logic                      freeze,
    output logic                      id_hold,
    output logic                      bubble,
    output logic                      branch_taken,
    output logic [mips_pkg::xlen-1:0] branch_target,
    output mips_pkg::id_ex_t          id_ex
);

    logic [mips_pkg::xlen-1:0]       rf [0:31];
    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    logic [mips_pkg::reg_addr_w-1:0] rs;
    logic [mips_pkg::reg_addr_w-1:0] rt;
    logic [mips_pkg::reg_addr_w-1:0] rd;
    logic [mips_pkg::xlen-1:0]       imm_ext;
    logic [mips_pkg::xlen-1:0]       wb_data;
    logic [mips_pkg::xlen-1:0]       rs_val;
    logic [mips_pkg::xlen-1:0]       rt_val;
    logic                            wb_hit;
    logic                            wb_we;
    logic                            is_beq;
    logic                            uses_rt;
    logic                            load_use;
    logic                            ex_hit;
    logic                            mem_hit;
    logic                            branch_hz;

    // Instruction fields
    assign opcode  = if_id.instr[31:26];
    assign rs      = if_id.instr[25:21];
    assign rt      = if_id.instr[20:16];
    assign rd      = if_id.instr[15:11];
    assign funct   = if_id.instr[5:0];
    assign imm_ext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

    //----------------------------------------------------------------
    // Writeback and register file
    //----------------------------------------------------------------
    assign wb_data = mem_wb_q.memread ? mem_wb_q.load_data : mem_wb_q.result;
    assign wb_hit  = mem_wb_q.regwrite && (mem_wb_q.dst != '0);
    // No write while frozen or in reset
    assign wb_we   = wb_hit && rst_n && !freeze;

    always_ff @(posedge clk) begin
        if (wb_we) begin
            rf[mem_wb_q.dst] <= wb_data;
        end
    end

    // Write-first reads, r0 reads as zero
    assign rs_val = (rs == '0) ? '0 : (wb_hit && mem_wb_q.dst == rs) ? wb_data : rf[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_hit && mem_wb_q.dst == rt) ? wb_data : rf[rt];

    //----------------------------------------------------------------
    // Control decode
    //----------------------------------------------------------------
    always_comb begin
        id_ex         = '0;
        id_ex.rs      = rs;
        id_ex.rt      = rt;
        id_ex.rs_data = rs_val;
        id_ex.rt_data = rt_val;
        id_ex.imm     = imm_ext;
        case (opcode)
            mips_pkg::op_special: begin
                id_ex.valid    = 1'b1;
                id_ex.regwrite = 1'b1;
                id_ex.dst      = rd;
                case (funct)
                    mips_pkg::fn_addu: id_ex.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: id_ex.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  id_ex.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   id_ex.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  id_ex.alu_op = mips_pkg::alu_slt;
                    default: begin
                        // Unknown function, drop as a nop
                        id_ex.valid    = 1'b0;
                        id_ex.regwrite = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_addiu: begin
                id_ex.valid    = 1'b1;
                id_ex.regwrite = 1'b1;
                id_ex.imm_sel  = 1'b1;
                id_ex.dst      = rt;
            end
            mips_pkg::op_lw: begin
                id_ex.valid    = 1'b1;
                id_ex.regwrite = 1'b1;
                id_ex.memread  = 1'b1;
                id_ex.imm_sel  = 1'b1;
                id_ex.dst      = rt;
            end
            mips_pkg::op_sw: begin
                id_ex.valid    = 1'b1;
                id_ex.memwrite = 1'b1;
                id_ex.imm_sel  = 1'b1;
            end
            // BEQ is done here, it only rides along as a nop
            mips_pkg::op_beq: id_ex.valid = 1'b1;
            default: ;
        endcase
    end

    //----------------------------------------------------------------
    // Hazards and branch
    //----------------------------------------------------------------
    assign is_beq  = (opcode == mips_pkg::op_beq);
    assign uses_rt = (opcode == mips_pkg::op_special) || (opcode == mips_pkg::op_sw) || is_beq;

    // Load in EX feeding this instruction, one bubble
    assign load_use = id_ex_q.valid && id_ex_q.memread && (id_ex_q.dst != '0) &&
                      ((id_ex_q.dst == rs && id_ex.valid) || (id_ex_q.dst == rt && uses_rt));

    // BEQ compares here, so producers in EX or MEM must drain to WB
    assign ex_hit  = id_ex_q.valid && id_ex_q.regwrite && (id_ex_q.dst != '0) &&
                     (id_ex_q.dst == rs || id_ex_q.dst == rt);
    assign mem_hit = ex_mem_q.valid && ex_mem_q.regwrite && (ex_mem_q.dst != '0) &&
                     (ex_mem_q.dst == rs || ex_mem_q.dst == rt);
    assign branch_hz = is_beq && (ex_hit || mem_hit);

    assign id_hold = load_use || branch_hz;
    assign bubble  = load_use || branch_hz;
    assign freeze  = !i_cache_stall_n || !d_cache_stall_n;

    // Target relative to the delay slot address
    assign branch_taken  = is_beq && !branch_hz && (rs_val == rt_val);
    assign branch_target = if_id.pc4 + {imm_ext[mips_pkg::xlen-3:0], 2'b00};

endmodule

`default_nettype wire

/* mips_execute.sv */
//--------------------------------------------------------------------
// Execute stage
// Operand forwarding from EX/MEM and MEM/WB, then the ALU
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
    input  mips_pkg::id_ex_t  id_ex_q,
    input  mips_pkg::ex_mem_t ex_mem_q,
    input  mips_pkg::mem_wb_t mem_wb_q,
    output mips_pkg::ex_mem_t ex_mem
);

    logic [mips_pkg::xlen-1:0] rs_fwd;
    logic [mips_pkg::xlen-1:0] rt_fwd;
    logic [mips_pkg::xlen-1:0] op_b;
    logic [mips_pkg::xlen-1:0] result;

    // Younger producer in EX/MEM overrides MEM/WB
    function automatic logic [mips_pkg::xlen-1:0] fwd(
        input logic [mips_pkg::reg_addr_w-1:0] src,
        input logic [mips_pkg::xlen-1:0]       reg_val,
        input mips_pkg::ex_mem_t               em,
        input mips_pkg::mem_wb_t               mw
    );
        logic [mips_pkg::xlen-1:0] val;
        val = reg_val;
        if (mw.regwrite && mw.dst != '0 && mw.dst == src) begin
            val = mw.memread ? mw.load_data : mw.result;
        end
        // Only ALU results leave EX/MEM, loads wait for MEM/WB
        if (em.valid && em.regwrite && !em.memread && em.dst != '0 && em.dst == src) begin
            val = em.result;
        end
        return val;
    endfunction

    assign rs_fwd = fwd(id_ex_q.rs, id_ex_q.rs_data, ex_mem_q, mem_wb_q);
    assign rt_fwd = fwd(id_ex_q.rt, id_ex_q.rt_data, ex_mem_q, mem_wb_q);
    assign op_b   = id_ex_q.imm_sel ? id_ex_q.imm : rt_fwd;

    //----------------------------------------------------------------
    // ALU
    //----------------------------------------------------------------
    always_comb begin
        case (id_ex_q.alu_op)
            mips_pkg::alu_sub: result = rs_fwd - op_b;
            mips_pkg::alu_and: result = rs_fwd & op_b;
            mips_pkg::alu_or:  result = rs_fwd | op_b;
            // Signed compare
            mips_pkg::alu_slt: result = {{(mips_pkg::xlen-1){1'b0}},
                                         ($signed(rs_fwd) < $signed(op_b))};
            default:           result = rs_fwd + op_b;
        endcase
    end

    assign ex_mem.valid      = id_ex_q.valid;
    assign ex_mem.memread    = id_ex_q.memread;
    assign ex_mem.memwrite   = id_ex_q.memwrite;
    assign ex_mem.regwrite   = id_ex_q.regwrite;
    assign ex_mem.dst        = id_ex_q.dst;
    assign ex_mem.result     = result;
    assign ex_mem.store_data = rt_fwd;

endmodule

`default_nettype wire

/* mips_fetch.sv */
//--------------------------------------------------------------------
// Fetch stage
// Program counter with branch redirect and the instruction request
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      freeze,
    input  logic                      id_hold,
    input  logic                      branch_taken,
    input  logic [mips_pkg::xlen-1:0] branch_target,
    input  logic [mips_pkg::xlen-1:0] idata,
    output logic [mips_pkg::xlen-1:0] iaddr,
    output logic                      ireq,
    output mips_pkg::if_id_t          if_id
);

    logic [mips_pkg::xlen-1:0] pc;
    logic [mips_pkg::xlen-1:0] pc4;

    assign pc4 = pc + mips_pkg::xlen'(4);

    // PC only moves when the whole front end moves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= mips_pkg::reset_pc;
        end else if (!freeze && !id_hold) begin
            pc <= branch_taken ? branch_target : pc4;
        end
    end

    // Request is up in every cycle out of reset
    assign ireq        = rst_n;
    assign iaddr       = pc;
    assign if_id.instr = idata;
    assign if_id.pc4   = pc4;

endmodule

`default_nettype wire

/* mips_memory.sv */
//--------------------------------------------------------------------
// Memory stage
// Word load and store request, load data into MEM/WB
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_memory (
    input  mips_pkg::ex_mem_t         ex_mem_q,
    input  logic [mips_pkg::xlen-1:0] drdata,
    output logic                      dreq,
    output logic                      dwrite,
    output logic [mips_pkg::xlen-1:0] daddr,
    output logic [mips_pkg::xlen-1:0] dwdata,
    output mips_pkg::mem_wb_t         mem_wb
);

    // Request straight from EX/MEM, held there on a data stall
    assign dreq   = ex_mem_q.valid && (ex_mem_q.memread || ex_mem_q.memwrite);
    assign dwrite = ex_mem_q.valid && ex_mem_q.memwrite;
    assign daddr  = ex_mem_q.result;
    assign dwdata = ex_mem_q.store_data;

    assign mem_wb.regwrite  = ex_mem_q.valid && ex_mem_q.regwrite;
    assign mem_wb.memread   = ex_mem_q.memread;
    assign mem_wb.dst       = ex_mem_q.dst;
    assign mem_wb.result    = ex_mem_q.result;
    // Load data is captured as returned, no alignment
    assign mem_wb.load_data = drdata;

endmodule

`default_nettype wire

/* mips_pkg.sv */
//--------------------------------------------------------------------
// MIPS pipeline shared definitions
// Widths, opcode and function codes, ALU operations and the
// payload structs carried between the pipeline stages
//--------------------------------------------------------------------
`default_nettype none

package mips_pkg;

    // Datapath and register number widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Fetch address after reset
    localparam logic [xlen-1:0] reset_pc = '0;

    //----------------------------------------------------------------
    // Primary opcodes
    //----------------------------------------------------------------
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] op_beq     = 6'h04;

    // SPECIAL function field
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    //----------------------------------------------------------------
    // Stage payloads, all zero means an empty slot
    //----------------------------------------------------------------
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc4;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        // Operand B from the immediate
        logic                  imm_sel;
        logic                  memread;
        logic                  memwrite;
        logic                  regwrite;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       rs_data;
        logic [xlen-1:0]       rt_data;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  memread;
        logic                  memwrite;
        logic                  regwrite;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  regwrite;
        logic                  memread;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* mips_stage_reg.sv */
//--------------------------------------------------------------------
// Pipeline stage register
// Carries any stage payload, holds on freeze or hold and
// loads an empty payload on bubble
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mips_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (!freeze) begin
            // Freeze wins over bubble so nothing moves on a cache stall
            if (bubble) begin
                q <= '0;
            end else if (!hold) begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mips_core.sv */
//--------------------------------------------------------------------
// Testbench for the five-stage MIPS core
// Instruction and data memory models, program and store tables,
// random cache stalls and the error summary
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    // One copy of the program is loaded twice back to back
    localparam int prog_len   = 21;
    localparam int exp_len    = 7;
    localparam int max_cycles = 4 * (2 * prog_len) + 50;

    logic        clk;
    logic        rst_n;
    logic        i_cache_stall_n;
    logic        d_cache_stall_n;
    logic        ireq;
    logic [31:0] iaddr;
    logic [31:0] idata;
    logic        dreq;
    logic        dwrite;
    logic [31:0] daddr;
    logic [31:0] dwdata;
    logic [31:0] drdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] prog [0:prog_len-1];
    logic [31:0] exp_addr [0:exp_len-1];
    logic [31:0] exp_data [0:exp_len-1];
    logic [31:0] pre_addr [0:1];
    logic [31:0] pre_data [0:1];

    // Architectural register values of the ALU chain
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] vc;
    logic [31:0] vd;
    logic [31:0] ve;
    logic [31:0] vf;
    logic [31:0] vg;

    logic        stall_en;
    logic [31:0] lfsr;
    logic [3:0]  rnd;
    int          bit_i;
    int          n_err;
    int          n_chk;
    int          n_st;
    int          cycles;

    function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        return {mips_pkg::op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial clk = 1'b0;
    always #20 clk = ~clk;

    mips_core i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_cache_stall_n (i_cache_stall_n),
        .d_cache_stall_n (d_cache_stall_n),
        .ireq            (ireq),
        .iaddr           (iaddr),
        .idata           (idata),
        .dreq            (dreq),
        .dwrite          (dwrite),
        .daddr           (daddr),
        .dwdata          (dwdata),
        .drdata          (drdata)
    );

    // Both memories answer in the same cycle
    assign idata  = imem[iaddr[7:2]];
    assign drdata = dmem[daddr[7:2]];

    //----------------------------------------------------------------
    // Store monitor
    //----------------------------------------------------------------
    // A store retires once the whole pipeline moves past it
    always @(negedge clk) begin
        if (rst_n && dreq && dwrite && d_cache_stall_n && i_cache_stall_n) begin
            dmem[daddr[7:2]] = dwdata;
            n_chk++;
            assert (n_st < 2 * exp_len) else begin
                n_err++;
                $display("unexpected extra store of %h to %h at %0t", dwdata, daddr, $time);
            end
            if (n_st < 2 * exp_len) begin
                assert (daddr == exp_addr[n_st % exp_len] && dwdata == exp_data[n_st % exp_len])
                else begin
                    n_err++;
                    $display("error at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, n_st, dwdata, daddr,
                             exp_data[n_st % exp_len], exp_addr[n_st % exp_len]);
                end
            end
            n_st++;
        end
    end

    // Two LFSR bits for each stall level
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            for (bit_i = 0; bit_i < 4; bit_i++) begin
                lfsr       = lfsr_next(lfsr);
                rnd[bit_i] = lfsr[0];
            end
            i_cache_stall_n = !(rnd[0] && rnd[1]);
            d_cache_stall_n = !(rnd[2] && rnd[3]);
        end else begin
            i_cache_stall_n = 1'b1;
            d_cache_stall_n = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, n_st, 2 * exp_len);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n           = 1'b0;
        i_cache_stall_n = 1'b1;
        d_cache_stall_n = 1'b1;
        stall_en        = 1'b0;
        lfsr            = 32'h7253;
        n_err           = 0;
        n_chk           = 0;
        n_st            = 0;
        cycles          = 0;

        // Dependent chain evaluated at the ISA level
        va = 32'd5;
        vb = va + 32'd7;
        vc = vb + va;
        vd = vc - vb;
        ve = vd & vc;
        vf = ve | vb;
        vg = ($signed(vf) < $signed(vc)) ? 32'd1 : 32'd0;

        pre_addr[0] = 32'h10;
        pre_data[0] = 32'h1000_0020;
        pre_addr[1] = 32'h14;
        pre_data[1] = 32'h0bad_0f00;

        prog[0]  = i_format(mips_pkg::op_addiu, 0, 1, 16'd5);
        prog[1]  = i_format(mips_pkg::op_addiu, 1, 2, 16'd7);
        prog[2]  = r_format(mips_pkg::fn_addu, 2, 1, 3);
        prog[3]  = r_format(mips_pkg::fn_subu, 3, 2, 4);
        prog[4]  = r_format(mips_pkg::fn_and, 4, 3, 5);
        prog[5]  = r_format(mips_pkg::fn_or, 5, 2, 6);
        prog[6]  = r_format(mips_pkg::fn_slt, 6, 3, 7);
        prog[7]  = i_format(mips_pkg::op_sw, 0, 7, 16'h40);
        prog[8]  = i_format(mips_pkg::op_sw, 0, 6, 16'h44);
        // Write to r0 is dropped
        prog[9]  = i_format(mips_pkg::op_addiu, 1, 0, 16'd9);
        prog[10] = i_format(mips_pkg::op_sw, 0, 0, 16'h48);
        // Load-use pair
        prog[11] = i_format(mips_pkg::op_lw, 0, 10, 16'h10);
        prog[12] = r_format(mips_pkg::fn_addu, 10, 1, 11);
        prog[13] = i_format(mips_pkg::op_sw, 0, 11, 16'h4c);
        // Taken BEQ on a fresh operand skips the store to 0x54
        prog[14] = i_format(mips_pkg::op_addiu, 0, 12, 16'd5);
        prog[15] = i_format(mips_pkg::op_beq, 12, 1, 16'd2);
        prog[16] = i_format(mips_pkg::op_sw, 0, 12, 16'h50);
        prog[17] = i_format(mips_pkg::op_sw, 0, 2, 16'h54);
        // Not taken
        prog[18] = i_format(mips_pkg::op_beq, 1, 2, 16'd1);
        prog[19] = i_format(mips_pkg::op_sw, 0, 3, 16'h58);
        prog[20] = i_format(mips_pkg::op_sw, 0, 4, 16'h5c);

        exp_addr[0] = 32'h40;
        exp_data[0] = vg;
        exp_addr[1] = 32'h44;
        exp_data[1] = vf;
        exp_addr[2] = 32'h48;
        exp_data[2] = 32'd0;
        exp_addr[3] = 32'h4c;
        exp_data[3] = pre_data[0] + va;
        exp_addr[4] = 32'h50;
        exp_data[4] = va;
        exp_addr[5] = 32'h58;
        exp_data[5] = vc;
        exp_addr[6] = 32'h5c;
        exp_data[6] = vd;

        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = 32'hd5a0_0000 ^ (i * 4);
        end
        for (int i = 0; i < 2; i++) begin
            dmem[pre_addr[i][7:2]] = pre_data[i];
        end
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < prog_len; i++) begin
                imem[p * prog_len + i] = prog[i];
            end
        end

        repeat (4) begin
            @(posedge clk);
            #1;
            n_chk++;
            assert (!ireq && !dreq && !dwrite) else begin
                n_err++;
                $display("error at %0t: request strobe high during reset", $time);
            end
        end
        rst_n = 1'b1;
        // Word 0 is taken on the first edge after release
        @(negedge clk);
        n_chk++;
        assert (ireq && iaddr == 32'h0) else begin
            n_err++;
            $display("error at %0t: first fetch ireq %b address %h, expected request at 0",
                     $time, ireq, iaddr);
        end

        // Second copy of the program runs under random stalls
        wait (n_st == exp_len);
        stall_en = 1'b1;
        wait (iaddr >= 4 * (2 * prog_len + 4));
        repeat (2) @(negedge clk);
        n_chk++;
        assert (n_st == 2 * exp_len) else begin
            n_err++;
            $display("missing stores, saw %0d of %0d", n_st, 2 * exp_len);
        end

        $display("checks %0d, errors %0d, stores %0d, cycles %0d", n_chk, n_err, n_st, cycles);
        if (n_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
